// ==== hw/mul_pkg.sv ====
package mul_pkg;

  // datapath and tag widths
  localparam int XLEN       = 32;
  localparam int ROB_W      = 3;
  localparam int RS_IDX_W   = 3;
  localparam int RS_ENTRIES = 2 ** RS_IDX_W;
  localparam int CDB_PORTS  = 2;

  // rv32m multiply funct3 codes
  localparam logic [2:0] FUNCT3_MUL    = 3'd0;
  localparam logic [2:0] FUNCT3_MULH   = 3'd1;
  localparam logic [2:0] FUNCT3_MULHSU = 3'd2;
  localparam logic [2:0] FUNCT3_MULHU  = 3'd3;

  // sign treatment of a and b
  typedef enum logic [1:0] {
    KIND_SS,
    KIND_SU,
    KIND_UU
  } mul_kind_e;

  // one source operand as seen at issue
  typedef struct packed {
    logic             regfile_ready;
    logic [XLEN-1:0]  regfile_v;
    logic             rob_ready;
    logic [XLEN-1:0]  rob_v;
    logic [ROB_W-1:0] tag;
  } operand_src_t;

  typedef struct packed {
    logic [2:0]       funct3;
    operand_src_t     rs1;
    operand_src_t     rs2;
    logic [ROB_W-1:0] target_rob;
  } mul_issue_t;

  typedef struct packed {
    logic             valid;
    logic [ROB_W-1:0] rob;
    logic [XLEN-1:0]  value;
  } cdb_t;

  typedef struct packed {
    logic             valid;
    logic [ROB_W-1:0] rob;
    logic [XLEN-1:0]  p;
  } mul_result_t;

endpackage

// ==== hw/shift_add_multiplier.sv ====
module shift_add_multiplier (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  mul_pkg::mul_kind_e         kind,
  input  logic [mul_pkg::XLEN-1:0]   a,
  input  logic [mul_pkg::XLEN-1:0]   b,
  output logic [2*mul_pkg::XLEN-1:0] p,
  output logic                       done
);
  import mul_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_FIX
  } state_e;

  state_e                      state;
  logic [$clog2(XLEN)-1:0]     step;

  // working registers
  logic [2*XLEN-1:0]           acc;
  logic [2*XLEN-1:0]           mcand;
  logic [XLEN-1:0]             mplier;
  logic                        neg;

  logic                        a_neg;
  logic                        b_neg;
  logic [XLEN-1:0]             a_mag;
  logic [XLEN-1:0]             b_mag;

  // b is only signed in the signed-signed case
  assign a_neg = (kind != KIND_UU) && a[XLEN-1];
  assign b_neg = (kind == KIND_SS) && b[XLEN-1];
  // most negative value maps to 2**31 as unsigned
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      step  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_RUN;
            step  <= '0;
          end
        end
        ST_RUN: begin
          step <= step + 1'b1;
          if (step == $clog2(XLEN)'(XLEN - 1)) begin
            state <= ST_FIX;
          end
        end
        ST_FIX: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // datapath, one partial product per run cycle
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      acc    <= '0;
      mcand  <= {{XLEN{1'b0}}, a_mag};
      mplier <= b_mag;
      neg    <= a_neg ^ b_neg;
    end else if (state == ST_RUN) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // sign fix during the last cycle
  assign p    = neg ? -acc : acc;
  assign done = (state == ST_FIX);

  a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    start |-> state == ST_IDLE);

endmodule

// ==== hw/mul_station.sv ====
module mul_station (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         issue,
  input  mul_pkg::mul_issue_t          issue_data,
  input  mul_pkg::cdb_t                cdb [mul_pkg::CDB_PORTS],
  output logic                         full,
  output logic                         mul_start,
  output logic [mul_pkg::XLEN-1:0]     mul_a,
  output logic [mul_pkg::XLEN-1:0]     mul_b,
  output mul_pkg::mul_kind_e           mul_kind,
  input  logic [2*mul_pkg::XLEN-1:0]   mul_p,
  input  logic                         mul_done,
  output mul_pkg::mul_result_t         result
);
  import mul_pkg::*;

  // entry storage
  logic [RS_ENTRIES-1:0] busy;
  logic [2:0]            funct3_q   [RS_ENTRIES];
  logic [XLEN-1:0]       rs1_v      [RS_ENTRIES];
  logic [XLEN-1:0]       rs2_v      [RS_ENTRIES];
  logic [RS_ENTRIES-1:0] rs1_rdy;
  logic [RS_ENTRIES-1:0] rs2_rdy;
  logic [ROB_W-1:0]      rs1_tag    [RS_ENTRIES];
  logic [ROB_W-1:0]      rs2_tag    [RS_ENTRIES];
  logic [ROB_W-1:0]      target_rob [RS_ENTRIES];

  logic                  free_found;
  logic [RS_IDX_W-1:0]   free_idx;
  logic                  pick_found;
  logic [RS_IDX_W-1:0]   pick_idx;
  logic [RS_IDX_W-1:0]   rr_ptr;

  // operation currently in the multiplier
  logic                  in_flight;
  logic [RS_IDX_W-1:0]   exec_idx;
  logic [ROB_W-1:0]      exec_rob;
  logic [2:0]            exec_funct3;

  // regfile first, then rob
  function automatic logic [XLEN-1:0] src_value(operand_src_t src);
    if (src.regfile_ready) begin
      return src.regfile_v;
    end
    return src.rob_v;
  endfunction

  function automatic logic src_ready(operand_src_t src);
    return src.regfile_ready | src.rob_ready;
  endfunction

  function automatic mul_kind_e kind_of(logic [2:0] f3);
    case (f3)
      FUNCT3_MUL, FUNCT3_MULH: return KIND_SS;
      FUNCT3_MULHSU:           return KIND_SU;
      FUNCT3_MULHU:            return KIND_UU;
      default:                 return KIND_SS;
    endcase
  endfunction

  // lowest free slot
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (!busy[i] && !free_found) begin
        free_found = 1'b1;
        free_idx   = RS_IDX_W'(i);
      end
    end
  end

  assign full = !free_found;

  // round-robin pick starting at rr_ptr
  always_comb begin
    logic [RS_IDX_W-1:0] idx;
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int i = 0; i < RS_ENTRIES; i++) begin
      idx = rr_ptr + RS_IDX_W'(i);
      if (!pick_found && busy[idx] && rs1_rdy[idx] && rs2_rdy[idx]) begin
        pick_found = 1'b1;
        pick_idx   = idx;
      end
    end
  end

  // issue, cdb snoop and pop
  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= '0;
      rs1_rdy <= '0;
      rs2_rdy <= '0;
      rr_ptr  <= '0;
    end else begin
      if (issue && free_found) begin
        busy[free_idx]       <= 1'b1;
        funct3_q[free_idx]   <= issue_data.funct3;
        target_rob[free_idx] <= issue_data.target_rob;
        rs1_v[free_idx]      <= src_value(issue_data.rs1);
        rs2_v[free_idx]      <= src_value(issue_data.rs2);
        rs1_rdy[free_idx]    <= src_ready(issue_data.rs1);
        rs2_rdy[free_idx]    <= src_ready(issue_data.rs2);
        rs1_tag[free_idx]    <= issue_data.rs1.tag;
        rs2_tag[free_idx]    <= issue_data.rs2.tag;
      end

      // only occupied entries listen, so a same-cycle beat is missed
      for (int i = 0; i < RS_ENTRIES; i++) begin
        for (int j = 0; j < CDB_PORTS; j++) begin
          if (busy[i] && cdb[j].valid) begin
            if (!rs1_rdy[i] && cdb[j].rob == rs1_tag[i]) begin
              rs1_v[i]   <= cdb[j].value;
              rs1_rdy[i] <= 1'b1;
            end
            if (!rs2_rdy[i] && cdb[j].rob == rs2_tag[i]) begin
              rs2_v[i]   <= cdb[j].value;
              rs2_rdy[i] <= 1'b1;
            end
          end
        end
      end

      if (mul_done) begin
        busy[exec_idx] <= 1'b0;
        rr_ptr         <= exec_idx + 1'b1;
      end
    end
  end

  // dispatch to the multiplier
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= 1'b0;
      mul_start <= 1'b0;
    end else begin
      mul_start <= 1'b0;
      if (!in_flight && pick_found) begin
        in_flight   <= 1'b1;
        mul_start   <= 1'b1;
        exec_idx    <= pick_idx;
        exec_rob    <= target_rob[pick_idx];
        exec_funct3 <= funct3_q[pick_idx];
        mul_a       <= rs1_v[pick_idx];
        mul_b       <= rs2_v[pick_idx];
        mul_kind    <= kind_of(funct3_q[pick_idx]);
      end
      if (mul_done) begin
        in_flight <= 1'b0;
      end
    end
  end

  // low word for mul, high word otherwise
  always_comb begin
    result.valid = mul_done;
    result.rob   = exec_rob;
    if (exec_funct3 == FUNCT3_MUL) begin
      result.p = mul_p[XLEN-1:0];
    end else begin
      result.p = mul_p[2*XLEN-1:XLEN];
    end
  end

  a_no_issue_when_full: assert property (@(posedge clk) disable iff (rst)
    issue |-> !full);

  a_done_needs_flight: assert property (@(posedge clk) disable iff (rst)
    mul_done |-> in_flight);

  a_start_single: assert property (@(posedge clk) disable iff (rst)
    mul_start |=> !mul_start);

endmodule

// ==== hw/mul_unit.sv ====
module mul_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue,
  input  mul_pkg::mul_issue_t   issue_data,
  input  mul_pkg::cdb_t         cdb [mul_pkg::CDB_PORTS],
  output logic                  full,
  output mul_pkg::mul_result_t  result
);
  import mul_pkg::*;

  // station to multiplier
  logic              mul_start;
  logic [XLEN-1:0]   mul_a;
  logic [XLEN-1:0]   mul_b;
  mul_kind_e         mul_kind;

  // multiplier back to station
  logic [2*XLEN-1:0] mul_p;
  logic              mul_done;

  mul_station u_station (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .issue_data (issue_data),
    .cdb        (cdb),
    .full       (full),
    .mul_start  (mul_start),
    .mul_a      (mul_a),
    .mul_b      (mul_b),
    .mul_kind   (mul_kind),
    .mul_p      (mul_p),
    .mul_done   (mul_done),
    .result     (result)
  );

  // 33 cycles from start to done
  shift_add_multiplier u_mult (
    .clk   (clk),
    .rst   (rst),
    .start (mul_start),
    .kind  (mul_kind),
    .a     (mul_a),
    .b     (mul_b),
    .p     (mul_p),
    .done  (mul_done)
  );

endmodule

// ==== verif/mul_tb_ref.svh ====
`ifndef MUL_TB_REF_SVH
`define MUL_TB_REF_SVH

// rv32m result from a 64-bit product of sign or zero extended operands
function automatic logic [31:0] ref_mul(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic [63:0]        ub;
  logic [63:0]        prod;
  sa = {{32{a[31]}}, a};
  sb = {{32{b[31]}}, b};
  ub = {32'b0, b};
  case (f3)
    FUNCT3_MUL, FUNCT3_MULH: prod = sa * sb;
    FUNCT3_MULHSU:           prod = sa * $signed(ub);
    default:                 prod = {32'b0, a} * ub;
  endcase
  return (f3 == FUNCT3_MUL) ? prod[31:0] : prod[63:32];
endfunction

task automatic check_result(input mul_result_t exp, input mul_result_t act);
  checks++;
  if (act.p !== exp.p) begin
    errors++;
    $display("FAIL t=%0t result.p (rob %0d) exp=%h act=%h", $time, act.rob, exp.p, act.p);
  end
endtask

task automatic check_full(input logic exp, input logic act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("FAIL t=%0t full exp=%b act=%b", $time, exp, act);
  end
endtask

`endif

// ==== verif/mul_unit_tb.sv ====
module mul_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import mul_pkg::*;

  localparam int TAGS      = 2 ** ROB_W;
  localparam int TOTAL_OPS = 1 + 75 + 3 + 8 + 200;

  logic        clk = 1'b0;
  logic        rst;
  logic        issue;
  mul_issue_t  issue_data;
  cdb_t        cdb [CDB_PORTS];
  logic        full;
  mul_result_t result;

  // scoreboard indexed by target rob tag
  logic        out_valid [TAGS];
  logic [2:0]  exp_f3    [TAGS];
  logic [31:0] op_a      [TAGS];
  logic [31:0] op_b      [TAGS];
  logic        a_wait    [TAGS];
  logic        b_wait    [TAGS];
  logic [2:0]  a_tag     [TAGS];
  logic [2:0]  b_tag     [TAGS];
  int          outstanding = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_base = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  logic [31:0] corner [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

  `include "mul_tb_ref.svh"

  mul_unit dut (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .issue_data (issue_data),
    .cdb        (cdb),
    .full       (full),
    .result     (result)
  );

  always #20 clk = ~clk;

  function automatic operand_src_t make_src(logic rf, logic rb, logic [31:0] rf_v,
                                            logic [31:0] rb_v, logic [2:0] tag);
    operand_src_t s;
    s.regfile_ready = rf;
    s.regfile_v     = rf_v;
    s.rob_ready     = rb;
    s.rob_v         = rb_v;
    s.tag           = tag;
    return s;
  endfunction

  // regfile, rob or pending source, junk in unused fields
  function automatic operand_src_t rand_src();
    int k;
    k = $urandom_range(2);
    return make_src(k == 0, k == 1 || (k == 0 && $urandom_range(1) == 1),
                    $urandom, $urandom, 3'($urandom));
  endfunction

  function automatic int free_tag(int start);
    for (int i = 0; i < TAGS; i++) begin
      if (!out_valid[(start + i) % TAGS]) begin
        return (start + i) % TAGS;
      end
    end
    return -1;
  endfunction

  function automatic int waited_tag(int start);
    int t;
    for (int i = 0; i < TAGS; i++) begin
      t = (start + i) % TAGS;
      if (out_valid[t] && a_wait[t]) return a_tag[t];
      if (out_valid[t] && b_wait[t]) return b_tag[t];
    end
    return -1;
  endfunction

  task automatic next_cycle();
    @(negedge clk);
    issue = 1'b0;
    for (int j = 0; j < CDB_PORTS; j++) begin
      cdb[j].valid = 1'b0;
    end
  endtask

  task automatic drive_issue(logic [2:0] f3, operand_src_t s1, operand_src_t s2, int tgt);
    issue_data = '{funct3: f3, rs1: s1, rs2: s2, target_rob: 3'(tgt)};
    issue      = 1'b1;
    out_valid[tgt] = 1'b1;
    exp_f3[tgt] = f3;
    op_a[tgt]   = s1.regfile_ready ? s1.regfile_v : s1.rob_v;
    op_b[tgt]   = s2.regfile_ready ? s2.regfile_v : s2.rob_v;
    a_wait[tgt] = !(s1.regfile_ready || s1.rob_ready);
    b_wait[tgt] = !(s2.regfile_ready || s2.rob_ready);
    a_tag[tgt]  = s1.tag;
    b_tag[tgt]  = s2.tag;
    outstanding++;
  endtask

  task automatic issue_op(logic [2:0] f3, operand_src_t s1, operand_src_t s2);
    while (outstanding == RS_ENTRIES) begin
      check_full(1'b1, full);
      next_cycle();
    end
    check_full(1'b0, full);
    drive_issue(f3, s1, s2, free_tag(0));
    next_cycle();
  endtask

  // every waiting operand on this tag takes the value
  task automatic drive_beat(int port, logic [2:0] tag, logic [31:0] value);
    cdb[port] = '{valid: 1'b1, rob: tag, value: value};
    for (int t = 0; t < TAGS; t++) begin
      if (out_valid[t] && a_wait[t] && a_tag[t] == tag) begin
        op_a[t]   = value;
        a_wait[t] = 1'b0;
      end
      if (out_valid[t] && b_wait[t] && b_tag[t] == tag) begin
        op_b[t]   = value;
        b_wait[t] = 1'b0;
      end
    end
  endtask

  task automatic drain();
    while (outstanding > 0) begin
      check_full(outstanding == RS_ENTRIES, full);
      next_cycle();
    end
  endtask

  task automatic end_test(string name);
    if (errors == test_base) begin
      tests_ok++;
      $display("test %s: passed", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  // compare every result against the scoreboard
  always @(posedge clk) begin
    mul_result_t expd;
    if (!rst && result.valid) begin
      if (!out_valid[result.rob]) begin
        errors++;
        $display("t=%0t result for rob tag %0d with no outstanding operation", $time,
                 result.rob);
      end else begin
        if (a_wait[result.rob] || b_wait[result.rob]) begin
          errors++;
          $display("t=%0t rob tag %0d completed before its operands were broadcast", $time,
                   result.rob);
        end else begin
          expd   = result;
          expd.p = ref_mul(exp_f3[result.rob], op_a[result.rob], op_b[result.rob]);
          check_result(expd, result);
        end
        out_valid[result.rob] = 1'b0;
        outstanding--;
      end
    end
  end

  initial begin
    #(TOTAL_OPS * 40 * 40 + 2000);
    $display("watchdog expired with %0d operations outstanding", outstanding);
    for (int t = 0; t < TAGS; t++) begin
      if (out_valid[t]) $display("  rob tag %0d still outstanding", t);
    end
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int issued;
    int tag;
    void'($urandom(32'h9122));
    rst        = 1'b1;
    issue      = 1'b0;
    issue_data = '0;
    for (int j = 0; j < CDB_PORTS; j++) cdb[j] = '0;
    for (int t = 0; t < TAGS; t++) begin
      out_valid[t] = 1'b0;
      a_wait[t]    = 1'b0;
      b_wait[t]    = 1'b0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;

    check_full(1'b0, full);
    checks++;
    if (result.valid !== 1'b0) begin
      errors++;
      $display("FAIL t=%0t result.valid exp=0 act=%b", $time, result.valid);
    end
    issue_op(FUNCT3_MUL, make_src(1, 0, 32'h1234_5678, 0, 0),
             make_src(1, 0, 32'h9abc_def0, 0, 0));
    drain();
    end_test("reset_and_mul");

    // rs2 alternates between rob only and both ready with a different rob value
    for (int f = 1; f < 4; f++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          issue_op(3'(f), make_src(1, 0, corner[i], 0, 0),
                   (j % 2) ? make_src(0, 1, 0, corner[j], 0)
                           : make_src(1, 1, corner[j], ~corner[j], 0));
        end
      end
    end
    drain();
    end_test("corner_high_words");

    issue_op(FUNCT3_MUL, make_src(0, 0, 0, 0, 3'd5), make_src(1, 0, 32'd7, 0, 0));
    issue_op(FUNCT3_MULHU, make_src(1, 0, 32'hffff_fff0, 0, 0), make_src(0, 0, 0, 0, 3'd6));
    issue_op(FUNCT3_MULH, make_src(0, 0, 0, 0, 3'd5), make_src(0, 0, 0, 0, 3'd6));
    drive_beat(0, 3'd2, 32'hdead_beef);
    repeat (50) next_cycle();
    drive_beat(1, 3'd5, 32'h8000_0001);
    drive_beat(0, 3'd6, 32'h0001_0003);
    next_cycle();
    drain();
    end_test("cdb_wakeup");

    for (int i = 0; i < 8; i++) begin
      issue_op(3'(i % 4), make_src(0, 0, 0, 0, 3'(i)), make_src(1, 0, $urandom, 0, 0));
    end
    check_full(1'b1, full);
    for (int i = 0; i < 8; i++) begin
      drive_beat(i % 2, 3'(i), $urandom);
      next_cycle();
    end
    drain();
    end_test("fill_station");

    // issue and broadcast never share a cycle
    issued = 0;
    while (issued < 200 || outstanding > 0) begin
      check_full(outstanding == RS_ENTRIES, full);
      tag = waited_tag($urandom_range(TAGS - 1));
      if (tag >= 0 &&
          ($urandom_range(3) == 0 || issued == 200 || outstanding == RS_ENTRIES)) begin
        drive_beat($urandom_range(CDB_PORTS - 1), 3'(tag), $urandom);
      end else if (issued < 200 && outstanding < RS_ENTRIES && $urandom_range(1) == 1) begin
        drive_issue(3'($urandom_range(3)), rand_src(), rand_src(),
                    free_tag($urandom_range(TAGS - 1)));
        issued++;
      end
      next_cycle();
    end
    end_test("random_traffic");

    $display("tests passed: %0d, tests failed: %0d, checks: %0d, errors: %0d",
             tests_ok, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+verif
hw/mul_pkg.sv
hw/shift_add_multiplier.sv
hw/mul_station.sv
hw/mul_unit.sv
verif/mul_unit_tb.sv
